/* commit_pkg.sv */
//////////////////////////////
// commit subsystem package
// sizes, index and word types
// dispatch, cdb, retire and
// redirect packets, rob entry
//////////////////////////////

package commit_pkg;

    localparam int xlen        = 32;
    localparam int rob_size    = 16;
    localparam int rob_idx_len = 4;
    localparam int arch_regs   = 32;
    localparam int reg_idx_len = 5;

    localparam logic [reg_idx_len-1:0] zero_reg = '0;

    typedef logic [rob_idx_len-1:0] rob_tag_t;
    typedef logic [reg_idx_len-1:0] reg_idx_t;
    typedef logic [xlen-1:0]        word_t;

    typedef struct packed {
        logic           valid;
        word_t          pc;
        // predicted next pc
        word_t          npc;
        reg_idx_t       dest_reg;
        reg_idx_t [1:0] src_reg;
        logic           is_branch;
        logic           take_branch;
        logic           halt;
    } dispatch_packet;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
        // resolved direction
        logic     take_branch;
        word_t    branch_target;
    } cdb_packet;

    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } operand_packet;

    typedef struct packed {
        rob_tag_t            tag;
        operand_packet [1:0] src;
    } dispatch_reply;

    typedef struct packed {
        logic     valid;
        logic     dest_valid;
        reg_idx_t dest_reg;
        word_t    value;
        rob_tag_t tag;
        word_t    pc_plus_4;
    } retire_packet;

    typedef struct packed {
        logic  squash;
        word_t target_pc;
    } redirect_packet;

    typedef struct packed {
        logic     valid;
        logic     ready;
        word_t    pc;
        word_t    npc;
        reg_idx_t dest_reg;
        word_t    value;
        logic     is_branch;
        logic     take_branch;
        logic     mis_pred;
        word_t    branch_target;
        logic     halt;
    } rob_entry;

endpackage

/* rob.sv */
//////////////////////////////
// reorder buffer
// circular, 16 entries
// dispatch, two cdb ports,
// dual in-order retire, squash
//////////////////////////////

module rob import commit_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  dispatch_packet dispatch,
    input  cdb_packet      cdb_0,
    input  cdb_packet      cdb_1,
    input  rob_tag_t       read_tag_0,
    input  rob_tag_t       read_tag_1,
    output word_t          read_value_0,
    output word_t          read_value_1,
    output logic           read_ready_0,
    output logic           read_ready_1,
    output rob_tag_t       tail,
    output logic           full,
    output retire_packet   retire_0,
    output retire_packet   retire_1,
    output redirect_packet redirect,
    output logic           halt
);

    rob_tag_t               head;
    rob_tag_t               head_plus_1;
    rob_tag_t               next_head;
    logic [rob_idx_len:0]   count;
    logic [rob_idx_len:0]   next_count;
    rob_entry               entries [rob_size];

    rob_entry               head_entry;
    rob_entry               second_entry;
    rob_entry               new_entry;

    logic                   empty;
    logic                   dispatch_valid;
    logic                   retire_valid_0;
    logic                   retire_valid_1;
    logic                   squash_0;
    logic                   squash_1;
    logic                   squash;
    logic [1:0]             retire_count;
    logic                   cdb_hit_0;
    logic                   cdb_hit_1;

    assign head_plus_1    = head + 1'b1;
    assign head_entry     = entries[head];
    assign second_entry   = entries[head_plus_1];

    assign empty          = (count == '0);
    assign full           = (count == (rob_idx_len+1)'(rob_size));
    assign dispatch_valid = dispatch.valid && !full;

    assign cdb_hit_0      = cdb_0.valid && entries[cdb_0.tag].valid;
    assign cdb_hit_1      = cdb_1.valid && entries[cdb_1.tag].valid;

    //////////////////////////////
    // retire decision
    //////////////////////////////

    assign retire_valid_0 = !empty && head_entry.valid && head_entry.ready;

    // second port never follows a squash or a halt
    assign retire_valid_1 = retire_valid_0 && !squash_0 && !head_entry.halt &&
                            second_entry.valid && second_entry.ready &&
                            !second_entry.halt;

    assign squash_0 = retire_valid_0 &&
                      (head_entry.mis_pred ||
                       (head_entry.is_branch && head_entry.npc != head_entry.branch_target));
    assign squash_1 = retire_valid_1 &&
                      (second_entry.mis_pred ||
                       (second_entry.is_branch &&
                        second_entry.npc != second_entry.branch_target));
    assign squash   = squash_0 || squash_1;

    assign redirect.squash    = squash;
    assign redirect.target_pc = squash_0 ? head_entry.branch_target
                                         : second_entry.branch_target;

    assign halt = retire_valid_0 && head_entry.halt;

    assign retire_0.valid      = retire_valid_0;
    assign retire_0.dest_valid = retire_valid_0 && (head_entry.dest_reg != zero_reg);
    assign retire_0.dest_reg   = head_entry.dest_reg;
    assign retire_0.value      = head_entry.value;
    assign retire_0.tag        = head;
    assign retire_0.pc_plus_4  = head_entry.pc + 32'd4;

    assign retire_1.valid      = retire_valid_1;
    assign retire_1.dest_valid = retire_valid_1 && (second_entry.dest_reg != zero_reg);
    assign retire_1.dest_reg   = second_entry.dest_reg;
    assign retire_1.value      = second_entry.value;
    assign retire_1.tag        = head_plus_1;
    assign retire_1.pc_plus_4  = second_entry.pc + 32'd4;

    // operand read ports
    assign read_value_0 = entries[read_tag_0].value;
    assign read_value_1 = entries[read_tag_1].value;
    assign read_ready_0 = entries[read_tag_0].valid && entries[read_tag_0].ready;
    assign read_ready_1 = entries[read_tag_1].valid && entries[read_tag_1].ready;

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        new_entry             = '0;
        new_entry.valid       = 1'b1;
        new_entry.pc          = dispatch.pc;
        new_entry.npc         = dispatch.npc;
        new_entry.dest_reg    = dispatch.dest_reg;
        new_entry.is_branch   = dispatch.is_branch;
        new_entry.take_branch = dispatch.take_branch;
        new_entry.halt        = dispatch.halt;
    end

    assign retire_count = {1'b0, retire_valid_0} + {1'b0, retire_valid_1};
    assign next_head    = head + rob_tag_t'(retire_count);
    assign next_count   = count + (rob_idx_len+1)'(dispatch_valid)
                                - (rob_idx_len+1)'(retire_count);

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i].valid    <= 1'b0;
                entries[i].ready    <= 1'b0;
                entries[i].mis_pred <= 1'b0;
            end
        end else begin
            if (dispatch_valid) begin
                entries[tail] <= new_entry;
                tail          <= tail + 1'b1;
            end
            if (cdb_hit_0) begin
                entries[cdb_0.tag].ready         <= 1'b1;
                entries[cdb_0.tag].value         <= cdb_0.value;
                entries[cdb_0.tag].mis_pred      <=
                    entries[cdb_0.tag].take_branch != cdb_0.take_branch;
                entries[cdb_0.tag].branch_target <= cdb_0.branch_target;
            end
            if (cdb_hit_1) begin
                entries[cdb_1.tag].ready         <= 1'b1;
                entries[cdb_1.tag].value         <= cdb_1.value;
                entries[cdb_1.tag].mis_pred      <=
                    entries[cdb_1.tag].take_branch != cdb_1.take_branch;
                entries[cdb_1.tag].branch_target <= cdb_1.branch_target;
            end
            // free retired slots
            if (retire_valid_0) begin
                entries[head].valid <= 1'b0;
                entries[head].ready <= 1'b0;
            end
            if (retire_valid_1) begin
                entries[head_plus_1].valid <= 1'b0;
                entries[head_plus_1].ready <= 1'b0;
            end
            head  <= next_head;
            count <= next_count;
        end
    end

endmodule

/* map_table.sv */
//////////////////////////////
// rename map table
// arch reg to producing tag
// retire clear, squash flush
//////////////////////////////

module map_table import commit_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  logic           squash,
    input  dispatch_packet dispatch,
    input  rob_tag_t       tail,
    input  retire_packet   retire_0,
    input  retire_packet   retire_1,
    output logic           busy_0,
    output logic           busy_1,
    output rob_tag_t       src_tag_0,
    output rob_tag_t       src_tag_1
);

    logic [arch_regs-1:0] busy;
    rob_tag_t             tags [arch_regs];

    logic                 record;
    logic                 clear_0;
    logic                 clear_1;

    assign record  = dispatch.valid && (dispatch.dest_reg != zero_reg);

    // only clear when the retiring entry is still the newest producer
    assign clear_0 = retire_0.dest_valid && busy[retire_0.dest_reg] &&
                     (tags[retire_0.dest_reg] == retire_0.tag);
    assign clear_1 = retire_1.dest_valid && busy[retire_1.dest_reg] &&
                     (tags[retire_1.dest_reg] == retire_1.tag);

    assign busy_0    = busy[dispatch.src_reg[0]];
    assign busy_1    = busy[dispatch.src_reg[1]];
    assign src_tag_0 = tags[dispatch.src_reg[0]];
    assign src_tag_1 = tags[dispatch.src_reg[1]];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy <= '0;
        end else begin
            if (clear_0) begin
                busy[retire_0.dest_reg] <= 1'b0;
            end
            if (clear_1) begin
                busy[retire_1.dest_reg] <= 1'b0;
            end
            // newer dispatch overrides a same-cycle clear
            if (record) begin
                busy[dispatch.dest_reg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (record) begin
            tags[dispatch.dest_reg] <= tail;
        end
    end

endmodule

/* arch_regfile.sv */
//////////////////////////////
// architectural register file
// two retire write ports
// two dispatch read ports
//////////////////////////////

module arch_regfile import commit_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  retire_packet retire_0,
    input  retire_packet retire_1,
    input  reg_idx_t     read_reg_0,
    input  reg_idx_t     read_reg_1,
    output word_t        read_data_0,
    output word_t        read_data_1
);

    // register 0 is hardwired
    word_t regs [1:arch_regs-1];

    assign read_data_0 = (read_reg_0 == zero_reg) ? '0 : regs[read_reg_0];
    assign read_data_1 = (read_reg_1 == zero_reg) ? '0 : regs[read_reg_1];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < arch_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (retire_0.dest_valid) begin
                regs[retire_0.dest_reg] <= retire_0.value;
            end
            // younger retire wins on a clash
            if (retire_1.dest_valid) begin
                regs[retire_1.dest_reg] <= retire_1.value;
            end
        end
    end

endmodule

/* commit_top.sv */
//////////////////////////////
// commit subsystem top
// rob, map table, regfile
// dispatch operand resolution
//////////////////////////////

module commit_top import commit_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  dispatch_packet dispatch,
    input  cdb_packet      cdb_0,
    input  cdb_packet      cdb_1,
    output dispatch_reply  reply,
    output logic           full,
    output retire_packet   retire_0,
    output retire_packet   retire_1,
    output redirect_packet redirect,
    output logic           halt
);

    rob_tag_t tail;
    logic     busy_0;
    logic     busy_1;
    rob_tag_t src_tag_0;
    rob_tag_t src_tag_1;
    word_t    rob_value_0;
    word_t    rob_value_1;
    logic     rob_ready_0;
    logic     rob_ready_1;
    word_t    rf_value_0;
    word_t    rf_value_1;

    // regfile first, then a completed rob entry, else wait on the tag
    function automatic operand_packet resolve(input logic     busy,
                                              input rob_tag_t tag,
                                              input logic     rob_ready,
                                              input word_t    rob_value,
                                              input word_t    rf_value);
        operand_packet op;
        op.tag   = tag;
        op.ready = !busy || rob_ready;
        if (!busy) begin
            op.value = rf_value;
        end else if (rob_ready) begin
            op.value = rob_value;
        end else begin
            op.value = '0;
        end
        return op;
    endfunction

    assign reply.tag    = tail;
    assign reply.src[0] = resolve(busy_0, src_tag_0, rob_ready_0, rob_value_0, rf_value_0);
    assign reply.src[1] = resolve(busy_1, src_tag_1, rob_ready_1, rob_value_1, rf_value_1);

    rob rob_i (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb_0        (cdb_0),
        .cdb_1        (cdb_1),
        .read_tag_0   (src_tag_0),
        .read_tag_1   (src_tag_1),
        .read_value_0 (rob_value_0),
        .read_value_1 (rob_value_1),
        .read_ready_0 (rob_ready_0),
        .read_ready_1 (rob_ready_1),
        .tail         (tail),
        .full         (full),
        .retire_0     (retire_0),
        .retire_1     (retire_1),
        .redirect     (redirect),
        .halt         (halt)
    );

    map_table map_table_i (
        .clock     (clock),
        .reset     (reset),
        .squash    (redirect.squash),
        .dispatch  (dispatch),
        .tail      (tail),
        .retire_0  (retire_0),
        .retire_1  (retire_1),
        .busy_0    (busy_0),
        .busy_1    (busy_1),
        .src_tag_0 (src_tag_0),
        .src_tag_1 (src_tag_1)
    );

    arch_regfile arch_regfile_i (
        .clock       (clock),
        .reset       (reset),
        .retire_0    (retire_0),
        .retire_1    (retire_1),
        .read_reg_0  (dispatch.src_reg[0]),
        .read_reg_1  (dispatch.src_reg[1]),
        .read_data_0 (rf_value_0),
        .read_data_1 (rf_value_1)
    );

endmodule

/* commit_assert.sv */
//////////////////////////////
// rob invariant checks
// count, full and retire port
// ordering, bound into rob
//////////////////////////////

module commit_assert import commit_pkg::*; (
    input logic                 clock,
    input logic                 reset,
    input logic [rob_idx_len:0] count,
    input rob_tag_t             head,
    input rob_tag_t             tail,
    input logic                 full,
    input retire_packet         retire_0,
    input retire_packet         retire_1
);

    // failures seen so far
    int fail_count = 0;

    count_in_range: assert property (@(posedge clock) disable iff (reset)
        count <= rob_size)
        else begin
            fail_count++;
            $error("rob count %0d above capacity", count);
        end

    full_pointers: assert property (@(posedge clock) disable iff (reset)
        full |-> head == tail)
        else begin
            fail_count++;
            $error("rob full with head %0d and tail %0d", head, tail);
        end

    // port 1 only retires behind port 0
    retire_order: assert property (@(posedge clock) disable iff (reset)
        retire_1.valid |-> retire_0.valid)
        else begin
            fail_count++;
            $error("retire port 1 valid without port 0");
        end

endmodule

bind rob commit_assert commit_assert_i (
    .clock    (clock),
    .reset    (reset),
    .count    (count),
    .head     (head),
    .tail     (tail),
    .full     (full),
    .retire_0 (retire_0),
    .retire_1 (retire_1)
);

/* commit_tb.sv */
//////////////////////////////
// commit subsystem testbench
// clock, reset, stimulus
// queue model of rob and regs
// per-cycle compare, report
//////////////////////////////

module commit_tb import commit_pkg::*; ();

    typedef struct packed {
        dispatch_reply  reply;
        retire_packet   retire_0;
        retire_packet   retire_1;
        redirect_packet redirect;
        logic           halt;
        logic           full;
    } expect_t;

    logic           clock;
    logic           reset;
    dispatch_packet dispatch;
    cdb_packet      cdb_0;
    cdb_packet      cdb_1;
    dispatch_reply  reply;
    logic           full;
    retire_packet   retire_0;
    retire_packet   retire_1;
    redirect_packet redirect;
    logic           halt;

    rob_entry m_rob [$];
    rob_tag_t m_head;
    word_t    m_regs [arch_regs];
    expect_t  exp;

    int    seed = 32'h2d1f;
    string test_name = "reset";
    int    check_count = 0;
    int    error_count = 0;
    int    test_count = 0;
    int    start_checks;
    int    start_errors;
    int    total_errors;
    logic  squash_seen;
    logic  halt_seen;

    commit_top commit_top_i (
        .clock    (clock),
        .reset    (reset),
        .dispatch (dispatch),
        .cdb_0    (cdb_0),
        .cdb_1    (cdb_1),
        .reply    (reply),
        .full     (full),
        .retire_0 (retire_0),
        .retire_1 (retire_1),
        .redirect (redirect),
        .halt     (halt)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic void model_reset();
        m_rob.delete();
        m_head = '0;
        foreach (m_regs[i]) m_regs[i] = '0;
    endfunction

    // youngest in-flight writer of src is the producer
    function automatic operand_packet lookup_operand(input reg_idx_t src);
        operand_packet op;
        op.ready = 1'b1;
        op.tag   = '0;
        op.value = m_regs[src];
        if (src != zero_reg) begin
            for (int i = 0; i < m_rob.size(); i++) begin
                if (m_rob[i].dest_reg == src) begin
                    op.tag   = m_head + rob_tag_t'(i);
                    op.ready = m_rob[i].ready;
                    op.value = m_rob[i].ready ? m_rob[i].value : '0;
                end
            end
        end
        return op;
    endfunction

    function automatic retire_packet retire_of(input rob_entry ent, input rob_tag_t tag);
        retire_packet r;
        r            = '0;
        r.valid      = 1'b1;
        r.dest_valid = (ent.dest_reg != zero_reg);
        r.dest_reg   = ent.dest_reg;
        r.value      = ent.value;
        r.tag        = tag;
        r.pc_plus_4  = ent.pc + 32'd4;
        return r;
    endfunction

    function automatic logic takes_squash(input rob_entry ent);
        return ent.mis_pred || (ent.is_branch && ent.npc != ent.branch_target);
    endfunction

    function automatic void apply_completion(input cdb_packet c);
        rob_tag_t idx;
        idx = c.tag - m_head;
        if (c.valid && int'(idx) < m_rob.size()) begin
            m_rob[idx].ready         = 1'b1;
            m_rob[idx].value         = c.value;
            m_rob[idx].mis_pred      = (c.take_branch != m_rob[idx].take_branch);
            m_rob[idx].branch_target = c.branch_target;
        end
    endfunction

    function automatic expect_t model_step(input dispatch_packet d, input cdb_packet c0,
                                           input cdb_packet c1);
        expect_t  e;
        rob_entry ent;
        logic     sq_0;
        logic     sq_1;
        int       n;
        e              = '0;
        sq_0           = 1'b0;
        sq_1           = 1'b0;
        e.full         = (m_rob.size() == rob_size);
        e.reply.tag    = m_head + rob_tag_t'(m_rob.size());
        e.reply.src[0] = lookup_operand(d.src_reg[0]);
        e.reply.src[1] = lookup_operand(d.src_reg[1]);
        if (m_rob.size() > 0 && m_rob[0].ready) begin
            e.retire_0 = retire_of(m_rob[0], m_head);
            e.halt     = m_rob[0].halt;
            sq_0       = takes_squash(m_rob[0]);
            if (!sq_0 && !m_rob[0].halt && m_rob.size() > 1 && m_rob[1].ready &&
                !m_rob[1].halt) begin
                e.retire_1 = retire_of(m_rob[1], m_head + 1'b1);
                sq_1       = takes_squash(m_rob[1]);
            end
        end
        e.redirect.squash = sq_0 || sq_1;
        if (sq_0) begin
            e.redirect.target_pc = m_rob[0].branch_target;
        end else if (sq_1) begin
            e.redirect.target_pc = m_rob[1].branch_target;
        end
        // a squashing branch still writes its destination
        if (e.retire_0.dest_valid) m_regs[e.retire_0.dest_reg] = e.retire_0.value;
        if (e.retire_1.dest_valid) m_regs[e.retire_1.dest_reg] = e.retire_1.value;
        if (e.redirect.squash) begin
            m_rob.delete();
            m_head = '0;
        end else begin
            apply_completion(c0);
            apply_completion(c1);
            n = int'(e.retire_0.valid) + int'(e.retire_1.valid);
            for (int i = 0; i < n; i++) void'(m_rob.pop_front());
            m_head = m_head + rob_tag_t'(n);
            if (d.valid && !e.full) begin
                ent             = '0;
                ent.valid       = 1'b1;
                ent.pc          = d.pc;
                ent.npc         = d.npc;
                ent.dest_reg    = d.dest_reg;
                ent.is_branch   = d.is_branch;
                ent.take_branch = d.take_branch;
                ent.halt        = d.halt;
                m_rob.push_back(ent);
            end
        end
        return e;
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic compare_retire(input string port, input retire_packet e_in,
                                  input retire_packet a_in);
        retire_packet e;
        retire_packet a;
        e = e_in;
        a = a_in;
        // payload is don't-care on an idle port
        if (!e_in.valid) begin
            e       = '0;
            a       = '0;
            a.valid = a_in.valid;
        end
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, port, e, a);
        end
    endtask

    task automatic compare_reply(input dispatch_reply e_in, input dispatch_reply a_in);
        dispatch_reply e;
        dispatch_reply a;
        e = e_in;
        a = a_in;
        for (int s = 0; s < 2; s++) begin
            if (e_in.src[s].ready) begin
                e.src[s].tag = '0;
                a.src[s].tag = '0;
            end else begin
                e.src[s].value = '0;
                a.src[s].value = '0;
            end
        end
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("FAILED %s reply: expected %h, actual %h", test_name, e, a);
        end
    endtask

    task automatic compare_redirect(input redirect_packet e_in, input redirect_packet a_in);
        redirect_packet e;
        redirect_packet a;
        e = e_in;
        a = a_in;
        if (!e_in.squash) begin
            e.target_pc = '0;
            a.target_pc = '0;
        end
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("FAILED %s redirect: expected %h, actual %h", test_name, e, a);
        end
    endtask

    task automatic compare_flag(input string flag, input logic e, input logic a);
        check_count++;
        if (a !== e) begin
            error_count++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, flag, e, a);
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            model_reset();
        end else begin
            exp = model_step(dispatch, cdb_0, cdb_1);
            compare_retire("retire_0", exp.retire_0, retire_0);
            compare_retire("retire_1", exp.retire_1, retire_1);
            compare_redirect(exp.redirect, redirect);
            compare_flag("halt", exp.halt, halt);
            compare_flag("full", exp.full, full);
            if (dispatch.valid) compare_reply(exp.reply, reply);
            if (redirect.squash === 1'b1) squash_seen = 1'b1;
            if (halt === 1'b1) halt_seen = 1'b1;
        end
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    function automatic dispatch_packet make_inst(input word_t pc, input reg_idx_t dest,
                                                 input reg_idx_t src_a, input reg_idx_t src_b);
        dispatch_packet d;
        d            = '0;
        d.valid      = 1'b1;
        d.pc         = pc;
        d.npc        = pc + 32'd4;
        d.dest_reg   = dest;
        d.src_reg[0] = src_a;
        d.src_reg[1] = src_b;
        return d;
    endfunction

    function automatic cdb_packet completion(input rob_tag_t tag);
        cdb_packet c;
        c       = '0;
        c.valid = 1'b1;
        c.tag   = tag;
        c.value = $random(seed);
        return c;
    endfunction

    task automatic issue(input dispatch_packet d, output rob_tag_t tag);
        @(negedge clock);
        tag      = m_head + rob_tag_t'(m_rob.size());
        dispatch = d;
        cdb_0    = '0;
        cdb_1    = '0;
    endtask

    task automatic complete(input cdb_packet c0, input cdb_packet c1);
        @(negedge clock);
        dispatch = '0;
        cdb_0    = c0;
        cdb_1    = c1;
    endtask

    function automatic logic condition_met(input string what);
        case (what)
            "full":     return full === 1'b1;
            "not full": return full === 1'b0;
            "squash":   return squash_seen;
            "halt":     return halt_seen;
            default:    return m_rob.size() == 0;
        endcase
    endfunction

    task automatic wait_for(input string what);
        int cycles;
        cycles = 0;
        // 40 cycles covers the longest drain of a full rob
        while (!condition_met(what) && cycles < 40) begin
            complete('0, '0);
            cycles++;
        end
        if (!condition_met(what)) begin
            error_count++;
            $display("%s: timed out waiting for %s", test_name, what);
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        start_checks = check_count;
        start_errors = error_count;
        squash_seen  = 1'b0;
        halt_seen    = 1'b0;
    endtask

    task automatic end_test();
        test_count++;
        $display("%-18s %0d checks, %0d errors", test_name,
                 check_count - start_checks, error_count - start_errors);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_in_order();
        rob_tag_t t [6];
        begin_test("in_order_retire");
        for (int i = 0; i < 6; i++) begin
            issue(make_inst(32'h1000 + 4 * i, reg_idx_t'(i + 1), zero_reg, zero_reg), t[i]);
        end
        complete(completion(t[5]), completion(t[3]));
        complete(completion(t[1]), completion(t[4]));
        complete(completion(t[0]), completion(t[2]));
        wait_for("drain");
        end_test();
    endtask

    task automatic test_operands();
        rob_tag_t tx;
        rob_tag_t ta;
        rob_tag_t tc;
        begin_test("operand_resolve");
        issue(make_inst(32'h2000, 5'd9, 5'd1, 5'd2), tx);
        issue(make_inst(32'h2004, 5'd7, zero_reg, 5'd3), ta);
        complete(completion(ta), '0);
        // r7 from the completed entry, r9 waits on the head
        issue(make_inst(32'h2008, 5'd10, 5'd7, 5'd9), tc);
        complete(completion(tx), completion(tc));
        wait_for("drain");
        end_test();
    endtask

    task automatic test_full();
        rob_tag_t t [rob_size];
        begin_test("full");
        for (int i = 0; i < rob_size; i++) begin
            issue(make_inst(32'h3000 + 4 * i, reg_idx_t'(i + 1), reg_idx_t'(i), zero_reg), t[i]);
        end
        wait_for("full");
        complete(completion(t[0]), '0);
        wait_for("not full");
        for (int i = 1; i < rob_size - 1; i += 2) begin
            complete(completion(t[i]), completion(t[i + 1]));
        end
        complete(completion(t[rob_size - 1]), '0);
        wait_for("drain");
        end_test();
    endtask

    task automatic test_squash();
        dispatch_packet d;
        cdb_packet      c;
        rob_tag_t       tb;
        rob_tag_t       ty1;
        rob_tag_t       ty2;
        rob_tag_t       tz;
        begin_test("mispredict_squash");
        d           = make_inst(32'h100, zero_reg, zero_reg, zero_reg);
        d.is_branch = 1'b1;
        issue(d, tb);
        issue(make_inst(32'h104, 5'd11, zero_reg, zero_reg), ty1);
        issue(make_inst(32'h108, 5'd12, zero_reg, zero_reg), ty2);
        complete(completion(ty1), completion(ty2));
        // predicted not taken, resolves taken
        c               = completion(tb);
        c.take_branch   = 1'b1;
        c.branch_target = 32'h200;
        complete(c, '0);
        wait_for("squash");
        issue(make_inst(32'h200, 5'd13, 5'd11, 5'd12), tz);
        complete(completion(tz), '0);
        wait_for("drain");
        end_test();
    endtask

    task automatic test_halt();
        dispatch_packet d;
        rob_tag_t       t1;
        rob_tag_t       th;
        rob_tag_t       t2;
        begin_test("halt");
        issue(make_inst(32'h300, 5'd13, zero_reg, zero_reg), t1);
        d      = make_inst(32'h304, zero_reg, zero_reg, zero_reg);
        d.halt = 1'b1;
        issue(d, th);
        issue(make_inst(32'h308, 5'd14, 5'd13, zero_reg), t2);
        complete(completion(t1), completion(th));
        complete(completion(t2), '0);
        wait_for("halt");
        wait_for("drain");
        end_test();
    endtask

    initial begin
        reset       = 1'b1;
        dispatch    = '0;
        cdb_0       = '0;
        cdb_1       = '0;
        squash_seen = 1'b0;
        halt_seen   = 1'b0;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        test_in_order();
        test_operands();
        test_full();
        test_squash();
        test_halt();
        complete('0, '0);
        total_errors = error_count + commit_top_i.rob_i.commit_assert_i.fail_count;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", test_count,
                 check_count, error_count, commit_top_i.rob_i.commit_assert_i.fail_count);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
commit_pkg.sv
rob.sv
map_table.sv
arch_regfile.sv
commit_top.sv
commit_assert.sv
commit_tb.sv
